// File: src/vfu_pkg.sv
/*
 * Shared constants and types of the integer vector execution unit.
 * Element length is fixed at 32 bits and all operations are unsigned.
 * A request must carry 1 <= vl <= Vlen/8 elements at its element width.
 */
`default_nettype none

package vfu_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int unsigned Elen    = 32;
  localparam int unsigned Elenb   = Elen / 8;
  localparam int unsigned Vlen    = 256;
  localparam int unsigned NrVregs = 32;
  localparam int unsigned IdWidth = 2;

  typedef logic [$clog2(NrVregs)-1:0] vreg_idx_t;
  typedef logic [IdWidth-1:0]         vfu_id_t;

  // Code doubles as log2 of bytes per element
  typedef enum logic [1:0] {
    Sew8  = 2'd0,
    Sew16 = 2'd1,
    Sew32 = 2'd2
  } sew_e;

  typedef enum logic [2:0] {
    OpAdd, OpSub, OpAnd, OpOr, OpXor, OpMinu, OpMaxu
  } vfu_op_e;

  // Enough for Vlen/8 byte elements, plus one
  typedef logic [$clog2(Vlen/8):0] vl_t;

  typedef struct packed {
    vfu_id_t         id;
    vfu_op_e         op;
    sew_e            sew;
    vl_t             vl;
    vreg_idx_t       vs1;
    vreg_idx_t       vs2;
    vreg_idx_t       vd;
    logic            use_vs1;
    logic [Elen-1:0] rs1;
  } vfu_req_t;

endpackage

`default_nettype wire

// File: src/vfu_ifs.sv
/*
 * Internal valid/ready channels of the vector execution unit.
 * A transfer happens in a cycle with valid and ready both high.
 * NrLanes must match the value used by the connected modules.
 */
`timescale 1ns/1ps
`default_nettype none

// Operand word from the issuer to the ALU stage
interface vfu_word_if #(
  parameter int unsigned NrLanes = 2
);
  localparam int unsigned WordsPerVreg = vfu_pkg::Vlen / (NrLanes * vfu_pkg::Elen);
  localparam int unsigned AddrWidth    = $clog2(vfu_pkg::NrVregs * WordsPerVreg);

  logic                              valid;
  logic                              ready;
  vfu_pkg::vfu_op_e                  op;
  vfu_pkg::sew_e                     sew;
  // operand_a is vs1 or the scalar, operand_b is vs2
  logic [NrLanes*vfu_pkg::Elen-1:0]  operand_a;
  logic [NrLanes*vfu_pkg::Elen-1:0]  operand_b;
  logic [AddrWidth-1:0]              waddr;
  logic [NrLanes*vfu_pkg::Elenb-1:0] wbe;
  logic                              last;
  vfu_pkg::vfu_id_t                  id;

  modport issuer (output valid, op, sew, operand_a, operand_b, waddr, wbe, last, id,
                  input  ready);
  modport alu    (input  valid, op, sew, operand_a, operand_b, waddr, wbe, last, id,
                  output ready);
endinterface

// Result word from the ALU stage to the writeback
interface vfu_result_if #(
  parameter int unsigned NrLanes = 2
);
  localparam int unsigned WordsPerVreg = vfu_pkg::Vlen / (NrLanes * vfu_pkg::Elen);
  localparam int unsigned AddrWidth    = $clog2(vfu_pkg::NrVregs * WordsPerVreg);

  logic                              valid;
  logic                              ready;
  logic [NrLanes*vfu_pkg::Elen-1:0]  data;
  logic [AddrWidth-1:0]              waddr;
  logic [NrLanes*vfu_pkg::Elenb-1:0] wbe;
  logic                              last;
  vfu_pkg::vfu_id_t                  id;

  modport alu       (output valid, data, waddr, wbe, last, id, input  ready);
  modport writeback (input  valid, data, waddr, wbe, last, id, output ready);
endinterface

`default_nettype wire

// File: src/vfu_spill_reg.sv
/*
 * Two-entry valid/ready register with registered outputs.
 * Output is valid one cycle after an accepted input, order is kept.
 * Payload registers carry no reset, only the fill flags do.
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  // Slot a takes new data, slot b catches it when the output stalls
  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain;
  logic b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Room as long as one slot is free
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  // Slot b always holds the older item
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

// File: src/vfu_issue.sv
/*
 * Walks one instruction at a time over the register words of its vector.
 * No hazard check between instructions in flight, the sender must ensure it.
 * The request must stay stable while valid, as the queue output does.
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_issue #(
  parameter  int unsigned NrLanes      = 2,
  localparam int unsigned WordsPerVreg = vfu_pkg::Vlen / (NrLanes * vfu_pkg::Elen),
  localparam int unsigned AddrWidth    = $clog2(vfu_pkg::NrVregs * WordsPerVreg),
  localparam int unsigned WordWidth    = NrLanes * vfu_pkg::Elen
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  vfu_pkg::vfu_req_t    req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output logic [AddrWidth-1:0] vrf_raddr1_o,
  output logic [AddrWidth-1:0] vrf_raddr2_o,
  output logic                 vrf_re1_o,
  output logic                 vrf_re2_o,
  input  logic [WordWidth-1:0] vrf_rdata1_i,
  input  logic [WordWidth-1:0] vrf_rdata2_i,
  input  logic                 vrf_rvalid1_i,
  input  logic                 vrf_rvalid2_i,
  vfu_word_if.issuer           word_o
);

  localparam int unsigned BytesPerWord = NrLanes * vfu_pkg::Elenb;

  logic                 started_q;
  vfu_pkg::vl_t         done_q;
  logic [AddrWidth-1:0] vs1_ptr_q, vs2_ptr_q, vd_ptr_q;

  vfu_pkg::vl_t         done_cur, remaining, epw;
  logic [AddrWidth-1:0] vs1_ptr, vs2_ptr, vd_ptr;
  logic [WordWidth-1:0] scalar_rep;
  logic                 operands_ok, fire;

  ////////////////////////////////////////
  // Word pointers
  ////////////////////////////////////////

  // First word addresses come straight from the request
  always_comb begin
    if (started_q) begin
      vs1_ptr  = vs1_ptr_q;
      vs2_ptr  = vs2_ptr_q;
      vd_ptr   = vd_ptr_q;
      done_cur = done_q;
    end else begin
      vs1_ptr  = AddrWidth'(req_i.vs1 * WordsPerVreg);
      vs2_ptr  = AddrWidth'(req_i.vs2 * WordsPerVreg);
      vd_ptr   = AddrWidth'(req_i.vd * WordsPerVreg);
      done_cur = '0;
    end
  end

  // Elements per word at this width
  assign epw       = vfu_pkg::vl_t'(BytesPerWord >> req_i.sew);
  assign remaining = req_i.vl - done_cur;

  assign vrf_raddr1_o = vs1_ptr;
  assign vrf_raddr2_o = vs2_ptr;
  assign vrf_re1_o    = req_valid_i && req_i.use_vs1;
  assign vrf_re2_o    = req_valid_i;

  ////////////////////////////////////////
  // Word issue
  ////////////////////////////////////////

  assign operands_ok  = (!req_i.use_vs1 || vrf_rvalid1_i) && vrf_rvalid2_i;
  assign word_o.valid = req_valid_i && operands_ok;
  assign fire         = word_o.valid && word_o.ready;
  // Pop the queue with the last word
  assign req_ready_o  = fire && word_o.last;

  always_comb begin
    unique case (req_i.sew)
      vfu_pkg::Sew8:  scalar_rep = {BytesPerWord{req_i.rs1[7:0]}};
      vfu_pkg::Sew16: scalar_rep = {(BytesPerWord / 2){req_i.rs1[15:0]}};
      default:        scalar_rep = {NrLanes{req_i.rs1}};
    endcase
  end

  assign word_o.op        = req_i.op;
  assign word_o.sew       = req_i.sew;
  assign word_o.operand_a = req_i.use_vs1 ? vrf_rdata1_i : scalar_rep;
  assign word_o.operand_b = vrf_rdata2_i;
  assign word_o.waddr     = vd_ptr;
  assign word_o.id        = req_i.id;
  assign word_o.last      = remaining <= epw;

  // Tail bytes at or past vl stay disabled
  always_comb begin
    for (int b = 0; b < BytesPerWord; b++) begin
      word_o.wbe[b] = (b >> req_i.sew) < int'(remaining);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      started_q <= 1'b0;
      done_q    <= '0;
    end else if (fire) begin
      started_q <= !word_o.last;
      done_q    <= word_o.last ? '0 : done_cur + epw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      vs1_ptr_q <= vs1_ptr + 1'b1;
      vs2_ptr_q <= vs2_ptr + 1'b1;
      vd_ptr_q  <= vd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/vfu_alu_stage.sv
/*
 * Element-wise integer ALU over one register word, one pipeline stage.
 * Sub computes vs2 - vs1, min and max compare unsigned.
 * Carries never cross element boundaries.
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_alu_stage #(
  parameter int unsigned NrLanes = 2
) (
  input  logic      clk_i,
  input  logic      rst_i,
  vfu_word_if.alu   word_i,
  vfu_result_if.alu result_o
);

  // a is the first operand, b is vs2
  function automatic logic [vfu_pkg::Elen-1:0] elem_op(
    input vfu_pkg::vfu_op_e         op,
    input logic [vfu_pkg::Elen-1:0] a,
    input logic [vfu_pkg::Elen-1:0] b
  );
    unique case (op)
      vfu_pkg::OpAdd:  return b + a;
      vfu_pkg::OpSub:  return b - a;
      vfu_pkg::OpAnd:  return b & a;
      vfu_pkg::OpOr:   return b | a;
      vfu_pkg::OpXor:  return b ^ a;
      vfu_pkg::OpMinu: return (a < b) ? a : b;
      vfu_pkg::OpMaxu: return (a > b) ? a : b;
      default:         return '0;
    endcase
  endfunction

  logic [NrLanes*vfu_pkg::Elen-1:0] word_res;

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    logic [vfu_pkg::Elen-1:0]                         a, b, r32;
    logic [vfu_pkg::Elenb-1:0][vfu_pkg::Elen-1:0]     r8;
    logic [vfu_pkg::Elenb/2-1:0][vfu_pkg::Elen-1:0]   r16;

    assign a = word_i.operand_a[l*vfu_pkg::Elen +: vfu_pkg::Elen];
    assign b = word_i.operand_b[l*vfu_pkg::Elen +: vfu_pkg::Elen];

    // Every width computed in parallel, zero extended
    always_comb begin
      for (int e = 0; e < vfu_pkg::Elenb; e++) begin
        r8[e] = elem_op(word_i.op, {{(vfu_pkg::Elen-8){1'b0}}, a[8*e +: 8]},
                        {{(vfu_pkg::Elen-8){1'b0}}, b[8*e +: 8]});
      end
      for (int h = 0; h < vfu_pkg::Elenb / 2; h++) begin
        r16[h] = elem_op(word_i.op, {{(vfu_pkg::Elen-16){1'b0}}, a[16*h +: 16]},
                         {{(vfu_pkg::Elen-16){1'b0}}, b[16*h +: 16]});
      end
      r32 = elem_op(word_i.op, a, b);
    end

    assign word_res[l*vfu_pkg::Elen +: vfu_pkg::Elen] =
        (word_i.sew == vfu_pkg::Sew8)  ? {r8[3][7:0], r8[2][7:0], r8[1][7:0], r8[0][7:0]} :
        (word_i.sew == vfu_pkg::Sew16) ? {r16[1][15:0], r16[0][15:0]} : r32;
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  // Take a new word when empty or draining
  assign word_i.ready = !result_o.valid || result_o.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_o.valid <= 1'b0;
    end else if (word_i.ready) begin
      result_o.valid <= word_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_i.valid && word_i.ready) begin
      result_o.data  <= word_res;
      result_o.waddr <= word_i.waddr;
      result_o.wbe   <= word_i.wbe;
      result_o.last  <= word_i.last;
      result_o.id    <= word_i.id;
    end
  end

endmodule

`default_nettype wire

// File: src/vfu_writeback.sv
/*
 * Buffers results and drives the register file write port.
 * The last word of an instruction is written only together with
 * its response, so rsp_valid_o marks the final completed write.
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_writeback #(
  parameter  int unsigned NrLanes      = 2,
  localparam int unsigned WordsPerVreg = vfu_pkg::Vlen / (NrLanes * vfu_pkg::Elen),
  localparam int unsigned AddrWidth    = $clog2(vfu_pkg::NrVregs * WordsPerVreg)
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  vfu_result_if.writeback                   result_i,
  output logic [AddrWidth-1:0]              vrf_waddr_o,
  output logic [NrLanes*vfu_pkg::Elen-1:0]  vrf_wdata_o,
  output logic [NrLanes*vfu_pkg::Elenb-1:0] vrf_wbe_o,
  output logic                              vrf_we_o,
  input  logic                              vrf_wvalid_i,
  output vfu_pkg::vfu_id_t                  rsp_id_o,
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i
);

  typedef struct packed {
    logic [NrLanes*vfu_pkg::Elen-1:0]  data;
    logic [AddrWidth-1:0]              waddr;
    logic [NrLanes*vfu_pkg::Elenb-1:0] wbe;
    logic                              last;
    vfu_pkg::vfu_id_t                  id;
  } wb_item_t;

  wb_item_t in_item, out_item;
  logic     out_valid, write_done;

  assign in_item = '{data:  result_i.data,
                     waddr: result_i.waddr,
                     wbe:   result_i.wbe,
                     last:  result_i.last,
                     id:    result_i.id};

  vfu_spill_reg #(
    .T(wb_item_t)
  ) i_result_buf (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .data_i (in_item),
    .valid_i(result_i.valid),
    .ready_o(result_i.ready),
    .data_o (out_item),
    .valid_o(out_valid),
    .ready_i(write_done)
  );

  // Hold back the last write until the response can go
  assign vrf_we_o    = out_valid && (!out_item.last || rsp_ready_i);
  assign write_done  = vrf_we_o && vrf_wvalid_i;
  assign vrf_waddr_o = out_item.waddr;
  assign vrf_wdata_o = out_item.data;
  assign vrf_wbe_o   = out_item.wbe;

  assign rsp_valid_o = write_done && out_item.last;
  assign rsp_id_o    = out_item.id;

endmodule

`default_nettype wire

// File: src/vfu_top.sv
/*
 * Integer vector execution unit with plain valid/ready ports.
 * Responses come in request order, one per instruction.
 * Read and write enables hold address and data until their handshake.
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_top #(
  parameter  int unsigned NrLanes      = 2,
  localparam int unsigned WordsPerVreg = vfu_pkg::Vlen / (NrLanes * vfu_pkg::Elen),
  localparam int unsigned AddrWidth    = $clog2(vfu_pkg::NrVregs * WordsPerVreg),
  localparam int unsigned WordWidth    = NrLanes * vfu_pkg::Elen
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  vfu_pkg::vfu_req_t                 req_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  output logic [AddrWidth-1:0]              vrf_raddr1_o,
  output logic [AddrWidth-1:0]              vrf_raddr2_o,
  output logic                              vrf_re1_o,
  output logic                              vrf_re2_o,
  input  logic [WordWidth-1:0]              vrf_rdata1_i,
  input  logic [WordWidth-1:0]              vrf_rdata2_i,
  input  logic                              vrf_rvalid1_i,
  input  logic                              vrf_rvalid2_i,
  output logic [AddrWidth-1:0]              vrf_waddr_o,
  output logic [WordWidth-1:0]              vrf_wdata_o,
  output logic [NrLanes*vfu_pkg::Elenb-1:0] vrf_wbe_o,
  output logic                              vrf_we_o,
  input  logic                              vrf_wvalid_i,
  output vfu_pkg::vfu_id_t                  rsp_id_o,
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i
);

  vfu_pkg::vfu_req_t queue_req;
  logic              queue_valid, queue_ready;

  vfu_word_if   #(.NrLanes(NrLanes)) word_if ();
  vfu_result_if #(.NrLanes(NrLanes)) result_if ();

  // Two-entry request queue
  vfu_spill_reg #(
    .T(vfu_pkg::vfu_req_t)
  ) i_req_queue (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .data_i (req_i),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_o (queue_req),
    .valid_o(queue_valid),
    .ready_i(queue_ready)
  );

  vfu_issue #(
    .NrLanes(NrLanes)
  ) i_issue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (queue_req),
    .req_valid_i  (queue_valid),
    .req_ready_o  (queue_ready),
    .vrf_raddr1_o (vrf_raddr1_o),
    .vrf_raddr2_o (vrf_raddr2_o),
    .vrf_re1_o    (vrf_re1_o),
    .vrf_re2_o    (vrf_re2_o),
    .vrf_rdata1_i (vrf_rdata1_i),
    .vrf_rdata2_i (vrf_rdata2_i),
    .vrf_rvalid1_i(vrf_rvalid1_i),
    .vrf_rvalid2_i(vrf_rvalid2_i),
    .word_o       (word_if.issuer)
  );

  vfu_alu_stage #(
    .NrLanes(NrLanes)
  ) i_alu (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .word_i  (word_if.alu),
    .result_o(result_if.alu)
  );

  vfu_writeback #(
    .NrLanes(NrLanes)
  ) i_writeback (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .result_i    (result_if.writeback),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .vrf_we_o    (vrf_we_o),
    .vrf_wvalid_i(vrf_wvalid_i),
    .rsp_id_o    (rsp_id_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

`default_nettype wire

// File: dv/vfu_tb.sv
/*
 * Testbench for the vector execution unit with two lanes.
 * Register file model with random read delay, write gaps and response gaps.
 * Reads dv/vfu_patterns.txt, so it must run from the project root.
 * The patterns must avoid hazards between instructions in flight.
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_tb;

  localparam int unsigned NrLanes   = 2;
  localparam int unsigned WordBytes = NrLanes * vfu_pkg::Elenb;
  localparam int unsigned WordWidth = NrLanes * vfu_pkg::Elen;
  localparam int unsigned NrWords   = vfu_pkg::NrVregs * vfu_pkg::Vlen / WordWidth;
  localparam int unsigned AddrWidth = $clog2(NrWords);

  logic                 clk;
  logic                 rst;
  vfu_pkg::vfu_req_t    req;
  logic                 req_valid, req_ready;
  logic [AddrWidth-1:0] raddr1, raddr2, waddr;
  logic                 re1, re2, rvalid1, rvalid2;
  logic [WordWidth-1:0] rdata1, rdata2, wdata;
  logic [WordBytes-1:0] wbe;
  logic                 we, wvalid;
  vfu_pkg::vfu_id_t     rsp_id;
  logic                 rsp_valid, rsp_ready;

  // Register file model and pattern contents
  logic [WordWidth-1:0] mem [NrWords];
  vfu_pkg::vfu_req_t    instr_q[$];
  int unsigned          words_q[$];
  logic [AddrWidth-1:0] exp_addr_q[$];
  logic [WordWidth-1:0] exp_data_q[$];
  logic [15:0]          lfsr_q;

  vfu_top #(
    .NrLanes(NrLanes)
  ) DUT (
    .clk_i(clk), .rst_i(rst),
    .req_i(req), .req_valid_i(req_valid), .req_ready_o(req_ready),
    .vrf_raddr1_o(raddr1), .vrf_raddr2_o(raddr2), .vrf_re1_o(re1), .vrf_re2_o(re2),
    .vrf_rdata1_i(rdata1), .vrf_rdata2_i(rdata2),
    .vrf_rvalid1_i(rvalid1), .vrf_rvalid2_i(rvalid2),
    .vrf_waddr_o(waddr), .vrf_wdata_o(wdata), .vrf_wbe_o(wbe), .vrf_we_o(we),
    .vrf_wvalid_i(wvalid),
    .rsp_id_o(rsp_id), .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic end_with_failure();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = (val << 1) | int'(lfsr_q[0]);
    end
  endtask

  // One read port whose rvalid pulses after 0 to 3 waiting cycles
  task automatic serve_read(input logic re, input logic [AddrWidth-1:0] addr,
                            output logic rvalid, output logic [WordWidth-1:0] rdata,
                            inout int wait_cnt);
    rdata = mem[addr];
    if (!re) begin
      rvalid   = 1'b0;
      wait_cnt = -1;
    end else begin
      if (wait_cnt < 0) begin
        draw_bits(2, wait_cnt);
      end
      rvalid   = (wait_cnt == 0);
      wait_cnt = (wait_cnt == 0) ? -1 : wait_cnt - 1;
    end
  endtask

  task automatic apply_write(input logic [AddrWidth-1:0] addr,
                             input logic [WordWidth-1:0] data,
                             input logic [WordBytes-1:0] be);
    for (int b = 0; b < WordBytes; b++) begin
      if (be[b]) begin
        mem[addr][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic load_patterns();
    int                   fd, n, id, op, sew, vl, vs1, vs2, vd, use_vs1, epw;
    logic                 bad;
    logic [7:0]           tag;
    logic [31:0]          rs1, addr;
    logic [WordWidth-1:0] data;
    string                line;
    vfu_pkg::vfu_req_t    r;
    bad = 1'b0;
    // Fill words that no P line sets
    for (int a = 0; a < NrWords; a++) begin
      mem[a] = {24'h5A5A5A, 8'(a), 24'hA5A5A5, 8'(a)};
    end
    fd = $fopen("dv/vfu_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/vfu_patterns.txt");
      end_with_failure();
    end else begin
      while ($fgets(line, fd) != 0) begin
        tag = line.getc(0);
        if (tag == "P") begin
          n = $sscanf(line, "P %h %h", addr, data);
          bad |= (n != 2);
          mem[addr[AddrWidth-1:0]] = data;
        end else if (tag == "E") begin
          n = $sscanf(line, "E %h %h", addr, data);
          bad |= (n != 2);
          exp_addr_q.push_back(addr[AddrWidth-1:0]);
          exp_data_q.push_back(data);
        end else if (tag == "I") begin
          n = $sscanf(line, "I %d %d %d %d %d %d %d %d %h",
                      id, op, sew, vl, vs1, vs2, vd, use_vs1, rs1);
          bad |= (n != 9);
          r.id      = vfu_pkg::vfu_id_t'(id);
          r.op      = vfu_pkg::vfu_op_e'(op);
          r.sew     = vfu_pkg::sew_e'(sew);
          r.vl      = vfu_pkg::vl_t'(vl);
          r.vs1     = vfu_pkg::vreg_idx_t'(vs1);
          r.vs2     = vfu_pkg::vreg_idx_t'(vs2);
          r.vd      = vfu_pkg::vreg_idx_t'(vd);
          r.use_vs1 = (use_vs1 != 0);
          r.rs1     = rs1;
          instr_q.push_back(r);
          epw = WordBytes >> sew;
          words_q.push_back(int'((vl + epw - 1) / epw));
        end else if (tag != "#" && line.len() > 1) begin
          bad = 1'b1;
        end
      end
      $fclose(fd);
      if (bad) begin
        $display("Malformed line in dv/vfu_patterns.txt");
        end_with_failure();
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int                   cycle, next_req, rsp_count, tail, limit, total_words;
    int                   writes_seen, wait1, wait2, r;
    logic                 hold_pending;
    logic [AddrWidth-1:0] hold_addr;
    logic [WordWidth-1:0] hold_data;
    logic [WordBytes-1:0] hold_be;
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    rdata1    = '0;
    rdata2    = '0;
    rvalid1   = 1'b0;
    rvalid2   = 1'b0;
    wvalid    = 1'b0;
    rsp_ready = 1'b0;
    lfsr_q    = 16'd28;
    cycle = 0;
    next_req = 0;
    rsp_count = 0;
    tail = 0;
    writes_seen = 0;
    wait1 = -1;
    wait2 = -1;
    hold_pending = 1'b0;
    load_patterns();
    total_words = 0;
    foreach (words_q[i]) begin
      total_words += words_q[i];
    end
    limit = 200 * total_words + 500;

    while (tail < 20) begin
      @(negedge clk);
      cycle++;
      if (cycle > limit) begin
        $display("Timeout after %0d cycles with %0d of %0d responses",
                 cycle, rsp_count, instr_q.size());
        end_with_failure();
      end
      // Release after four reset edges
      if (cycle == 4) begin
        rst = 1'b0;
      end
      // Requests offered during reset must leave the queue empty
      req_valid = (cycle <= 3 || cycle >= 5) && (next_req < instr_q.size());
      if (req_valid) begin
        req = instr_q[next_req];
      end
      serve_read(re1, raddr1, rvalid1, rdata1, wait1);
      serve_read(re2, raddr2, rvalid2, rdata2, wait2);
      draw_bits(2, r);
      wvalid = (r != 0);
      draw_bits(2, r);
      rsp_ready = (r != 0);

      // Sample ahead of the next rising edge
      #1;
      if (cycle <= 5) begin
        check_value("vrf_re1_o", re1, 0);
        check_value("vrf_re2_o", re2, 0);
        check_value("vrf_we_o", we, 0);
        check_value("rsp_valid_o", rsp_valid, 0);
      end
      if (hold_pending) begin
        check_value("vrf_waddr_o", waddr, hold_addr);
        check_value("vrf_wdata_o", wdata, hold_data);
        check_value("vrf_wbe_o", wbe, hold_be);
      end
      hold_pending = we && !wvalid;
      hold_addr    = waddr;
      hold_data    = wdata;
      hold_be      = wbe;
      if (we && wvalid) begin
        apply_write(waddr, wdata, wbe);
        writes_seen++;
      end
      if (rsp_valid && rsp_ready) begin
        if (rsp_count >= instr_q.size()) begin
          $display("Response with id %0d arrived after the last instruction", rsp_id);
          end_with_failure();
        end else begin
          check_value("rsp_id_o", rsp_id, instr_q[rsp_count].id);
          check_value("writes before rsp_valid_o", writes_seen, words_q[rsp_count]);
          writes_seen = 0;
          rsp_count++;
        end
      end
      if (req_valid && req_ready && !rst) begin
        next_req++;
      end
      // A few idle cycles catch extra responses
      if (rsp_count == instr_q.size()) begin
        tail++;
      end
    end

    foreach (exp_addr_q[i]) begin
      check_value($sformatf("mem[%0h]", exp_addr_q[i]), mem[exp_addr_q[i]], exp_data_q[i]);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
src/vfu_pkg.sv
src/vfu_ifs.sv
src/vfu_spill_reg.sv
src/vfu_issue.sv
src/vfu_alu_stage.sv
src/vfu_writeback.sv
src/vfu_top.sv
dv/vfu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the vector unit testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing -Wno-fatal -f filelist.f --top-module vfu_tb -o vfu_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/vfu_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: dv/vfu_patterns.txt
# P addr data | E addr data | I id op sew vl vs1 vs2 vd use_vs1 rs1; addr, data, rs1 in hex
# op 0 add 1 sub 2 and 3 or 4 xor 5 minu 6 maxu; sew 0 8-bit 1 16-bit 2 32-bit
P 04 0101FF0280018105
P 05 11111111000000F0
P 08 FFFF000180FF7F10
P 09 222222220F000003
P 69 EEEEEEEEEEEEEEEE
P 6D DDDDDDDDDDDDDDDD
P 70 CCCCCCCCCCCCCCCC
I 0 0 0 8 1 2 3 1 00000000
I 1 1 0 8 1 2 4 1 00000000
I 2 2 0 8 1 2 5 1 00000000
I 3 3 0 8 1 2 6 1 00000000
I 0 4 0 8 1 2 7 1 00000000
I 1 5 0 8 1 2 8 1 00000000
I 2 6 0 8 1 2 9 1 00000000
I 3 0 1 4 1 2 10 1 00000000
I 0 1 1 4 1 2 11 1 00000000
I 1 2 1 4 1 2 12 1 00000000
I 2 3 1 4 1 2 13 1 00000000
I 3 4 1 4 1 2 14 1 00000000
I 0 5 1 4 1 2 15 1 00000000
I 1 6 1 4 1 2 16 1 00000000
I 2 0 2 2 1 2 17 1 00000000
I 3 1 2 2 1 2 18 1 00000000
I 0 2 2 2 1 2 19 1 00000000
I 1 3 2 2 1 2 20 1 00000000
I 2 4 2 2 1 2 21 1 00000000
I 3 5 2 2 1 2 22 1 00000000
I 0 6 2 2 1 2 23 1 00000000
I 1 0 0 8 0 2 24 0 ABCD12F1
I 2 4 1 4 0 2 25 0 55558001
I 3 3 1 6 1 2 26 1 00000000
I 0 6 2 3 1 2 27 1 00000000
I 1 0 0 5 1 2 28 1 00000000
E 0C 0000FF0300000015
E 10 FEFE01FF00FEFE0B
E 14 0101000080010100
E 18 FFFFFF0380FFFF15
E 1C FEFEFF0300FEFE15
E 20 0101000180017F05
E 24 FFFFFF0280FF8110
E 28 0100FF0301000015
E 2C FEFE00FF00FEFE0B
E 30 0101000080010100
E 34 FFFFFF0380FFFF15
E 38 FEFEFF0300FEFE15
E 3C 0101000180017F10
E 40 FFFFFF0280FF8105
E 44 0100FF0301010015
E 48 FEFD00FF00FDFE0B
E 4C 0101000080010100
E 50 FFFFFF0380FFFF15
E 54 FEFEFF0300FEFE15
E 58 0101FF0280018105
E 5C FFFF000180FF7F10
E 60 F0F0F1F271F07001
E 64 7FFE800000FEFF11
E 68 FFFFFF0380FFFF15
E 69 EEEEEEEE0F0000F3
E 6A 5A5A5A6AA5A5A56A
E 6C FFFF000180FF7F10
E 6D DDDDDDDD0F000003
E 6E 5A5A5A6EA5A5A56E
E 70 CCCCCC0300000015
E 71 5A5A5A71A5A5A571
